// ==== rv32_front_pkg.sv ====
package rv32_front_pkg;

    // data, instruction and address word.
    typedef logic [31:0] rv32_word;

    // register file index.
    typedef logic [4:0] rv32_reg;

    typedef logic [63:0] order_t;    // fetch order number.

    // word index into instruction memory.
    typedef logic [5:0] imem_addr_t;

    // rv32i major opcodes, bits 6 to 0 of the instruction.
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,     // conditional branches.
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,     // alu with immediate.
        op_reg   = 7'b0110011,     // alu register-register.
        op_csr   = 7'b1110011
    } rv32_opcode;

    // depth matches the width of imem_addr_t.
    localparam int IMEM_WORDS = 64;

    localparam rv32_word RESET_PC = 32'h0000_0000;

endpackage : rv32_front_pkg

// ==== regfile.sv ====
`timescale 1ns/1ps

module regfile
    import rv32_front_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  logic     load,
    input  rv32_reg  dest,
    input  rv32_word in_data,
    input  rv32_reg  src_a,
    input  rv32_reg  src_b,
    output rv32_word reg_a,
    output rv32_word reg_b
);
    rv32_word regs [1:31];    // x0 has no storage.

    // zero register, write bypass, then the array.
    function automatic rv32_word read_port(input rv32_reg src);
        rv32_word data;
        if (src == '0) begin
            data = '0;
        end else if (load && (dest == src)) begin
            data = in_data;
        end else begin
            data = regs[src];
        end
        return data;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && (dest != '0)) begin    // writes to x0 dropped.
            regs[dest] <= in_data;
        end
    end

    always_comb begin
        reg_a = read_port(src_a);
        reg_b = read_port(src_b);
    end

endmodule : regfile

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
    import rv32_front_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       stall,
    input  logic       redirect,
    input  rv32_word   redirect_pc,
    input  logic       imem_we,
    input  imem_addr_t imem_addr,
    input  rv32_word   imem_wdata,
    output rv32_word   instruction,
    output rv32_word   pc_rdata,
    output rv32_word   pc_wdata,
    output order_t     commit_order,
    output logic       prediction,
    output logic       valid
);
    rv32_word   pc;
    rv32_word   imem [IMEM_WORDS];
    imem_addr_t fetch_idx;
    rv32_word   fetch_word;
    rv32_opcode fetch_op;
    rv32_word   fetch_b_imm;
    rv32_word   fetch_j_imm;
    rv32_word   next_pc;
    logic       taken;
    logic       capture;
    order_t     order_cnt;    // order of the next captured word.

    // instruction memory, loaded from outside.
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    assign fetch_idx  = pc[7:2];
    assign fetch_word = imem[fetch_idx];

    // just enough decode for the predictor.
    assign fetch_op    = rv32_opcode'(fetch_word[6:0]);
    assign fetch_b_imm = {{20{fetch_word[31]}}, fetch_word[7], fetch_word[30:25],
                          fetch_word[11:8], 1'b0};
    assign fetch_j_imm = {{12{fetch_word[31]}}, fetch_word[19:12], fetch_word[20],
                          fetch_word[30:21], 1'b0};

    // jal always taken, backward branches taken.
    always_comb begin
        taken   = 1'b0;
        next_pc = pc + 32'd4;
        if (fetch_op == op_jal) begin
            taken   = 1'b1;
            next_pc = pc + fetch_j_imm;
        end else if ((fetch_op == op_br) && fetch_b_imm[31]) begin
            taken   = 1'b1;
            next_pc = pc + fetch_b_imm;
        end
    end

    // redirect beats stall.
    assign capture = !redirect && !stall;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc           <= RESET_PC;
            valid        <= 1'b0;
            prediction   <= 1'b0;
            commit_order <= '0;
            order_cnt    <= '0;
        end else if (redirect) begin
            pc         <= redirect_pc;
            valid      <= 1'b0;    // flush the word in flight.
            prediction <= 1'b0;
        end else if (capture) begin
            pc           <= next_pc;
            valid        <= 1'b1;
            prediction   <= taken;
            commit_order <= order_cnt;
            order_cnt    <= order_cnt + 64'd1;
        end
    end

    // fetch/decode payload.
    always_ff @(posedge clk) begin
        if (capture) begin
            instruction <= fetch_word;
            pc_rdata    <= pc;
            pc_wdata    <= next_pc;
        end
    end

endmodule : fetch_unit

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import rv32_front_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       reg_load,
    input  rv32_reg    rd_sel,
    input  rv32_word   rd_data,

    input  rv32_word   fd_instruction,
    input  rv32_word   fd_pc_rdata,
    input  rv32_word   fd_pc_wdata,
    input  order_t     fd_commit_order,
    input  logic       fd_prediction,
    input  logic       fd_valid,

    output rv32_opcode opcode,
    output logic [2:0] func3,
    output logic [6:0] func7,
    output rv32_reg    rs1_addr,
    output rv32_reg    rs2_addr,
    output rv32_reg    rd_addr,
    output rv32_word   rs1_data,
    output rv32_word   rs2_data,
    output rv32_word   i_imm,
    output rv32_word   s_imm,
    output rv32_word   b_imm,
    output rv32_word   u_imm,
    output rv32_word   j_imm,

    output rv32_word   instruction,
    output rv32_word   pc_rdata,
    output rv32_word   pc_wdata,
    output order_t     commit_order,
    output logic       prediction,
    output logic       valid
);
    assign opcode   = rv32_opcode'(fd_instruction[6:0]);
    assign func3    = fd_instruction[14:12];
    assign func7    = fd_instruction[31:25];
    assign rs1_addr = fd_instruction[19:15];
    assign rs2_addr = fd_instruction[24:20];
    assign rd_addr  = fd_instruction[11:7];

    // sign taken from bit 31 in all but u.
    assign i_imm = {{21{fd_instruction[31]}}, fd_instruction[30:20]};
    assign s_imm = {{21{fd_instruction[31]}}, fd_instruction[30:25], fd_instruction[11:7]};
    assign b_imm = {{20{fd_instruction[31]}}, fd_instruction[7], fd_instruction[30:25],
                    fd_instruction[11:8], 1'b0};
    assign u_imm = {fd_instruction[31:12], 12'h000};
    assign j_imm = {{12{fd_instruction[31]}}, fd_instruction[19:12], fd_instruction[20],
                    fd_instruction[30:21], 1'b0};

    regfile regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .load    (reg_load),
        .dest    (rd_sel),
        .in_data (rd_data),
        .src_a   (rs1_addr),
        .src_b   (rs2_addr),
        .reg_a   (rs1_data),
        .reg_b   (rs2_data)
    );

    // fetch context for the next stage.
    assign instruction  = fd_instruction;
    assign pc_rdata     = fd_pc_rdata;
    assign pc_wdata     = fd_pc_wdata;
    assign commit_order = fd_commit_order;
    assign prediction   = fd_prediction;
    assign valid        = fd_valid;

endmodule : decode_stage

// ==== rv32_front.sv ====
`timescale 1ns/1ps

module rv32_front
    import rv32_front_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic       stall,
    input  logic       redirect,
    input  rv32_word   redirect_pc,

    input  logic       imem_we,
    input  imem_addr_t imem_addr,
    input  rv32_word   imem_wdata,

    input  logic       reg_load,
    input  rv32_reg    rd_sel,
    input  rv32_word   rd_data,

    output rv32_opcode opcode,
    output logic [2:0] func3,
    output logic [6:0] func7,
    output rv32_reg    rs1_addr,
    output rv32_reg    rs2_addr,
    output rv32_reg    rd_addr,
    output rv32_word   rs1_data,
    output rv32_word   rs2_data,
    output rv32_word   i_imm,
    output rv32_word   s_imm,
    output rv32_word   b_imm,
    output rv32_word   u_imm,
    output rv32_word   j_imm,
    output rv32_word   instruction,
    output rv32_word   pc_rdata,
    output rv32_word   pc_wdata,
    output order_t     commit_order,
    output logic       prediction,
    output logic       valid
);
    // fetch/decode register outputs.
    rv32_word fd_instruction;
    rv32_word fd_pc_rdata;
    rv32_word fd_pc_wdata;
    order_t   fd_commit_order;
    logic     fd_prediction;
    logic     fd_valid;

    fetch_unit fetch_unit_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .instruction  (fd_instruction),
        .pc_rdata     (fd_pc_rdata),
        .pc_wdata     (fd_pc_wdata),
        .commit_order (fd_commit_order),
        .prediction   (fd_prediction),
        .valid        (fd_valid)
    );

    decode_stage decode_stage_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .reg_load        (reg_load),
        .rd_sel          (rd_sel),
        .rd_data         (rd_data),
        .fd_instruction  (fd_instruction),
        .fd_pc_rdata     (fd_pc_rdata),
        .fd_pc_wdata     (fd_pc_wdata),
        .fd_commit_order (fd_commit_order),
        .fd_prediction   (fd_prediction),
        .fd_valid        (fd_valid),
        .opcode          (opcode),
        .func3           (func3),
        .func7           (func7),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rd_addr         (rd_addr),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .i_imm           (i_imm),
        .s_imm           (s_imm),
        .b_imm           (b_imm),
        .u_imm           (u_imm),
        .j_imm           (j_imm),
        .instruction     (instruction),
        .pc_rdata        (pc_rdata),
        .pc_wdata        (pc_wdata),
        .commit_order    (commit_order),
        .prediction      (prediction),
        .valid           (valid)
    );

endmodule : rv32_front

// ==== rv32_front_assert.sv ====
`timescale 1ns/1ps

module rv32_front_assert
    import rv32_front_pkg::*;
(
    input logic       clk,
    input logic       arst_n,
    input logic       stall,
    input logic       redirect,
    input rv32_word   redirect_pc,
    input logic       imem_we,
    input imem_addr_t imem_addr,
    input rv32_word   imem_wdata,
    input logic       reg_load,
    input rv32_reg    rd_sel,
    input rv32_word   rd_data,
    input rv32_opcode opcode,
    input logic [2:0] func3,
    input logic [6:0] func7,
    input rv32_reg    rs1_addr,
    input rv32_reg    rs2_addr,
    input rv32_reg    rd_addr,
    input rv32_word   rs1_data,
    input rv32_word   rs2_data,
    input rv32_word   i_imm,
    input rv32_word   s_imm,
    input rv32_word   b_imm,
    input rv32_word   u_imm,
    input rv32_word   j_imm,
    input rv32_word   instruction,
    input rv32_word   pc_rdata,
    input rv32_word   pc_wdata,
    input order_t     commit_order,
    input logic       prediction,
    input logic       valid
);
    rv32_word     shadow [32];    // reference register file.
    rv32_word     imem_copy [IMEM_WORDS];    // words as loaded.
    rv32_word     exp_word;
    rv32_word     exp_i;
    rv32_word     exp_s;
    rv32_word     exp_b;
    rv32_word     exp_u;
    rv32_word     exp_j;
    rv32_word     exp_rs1;
    rv32_word     exp_rs2;
    rv32_word     exp_next;
    logic         exp_taken;
    logic [31:0]  fields;
    logic [31:0]  exp_fields;
    rv32_word     chain_pc;       // pc of the next valid instruction.
    order_t       last_order;     // order of the last valid instruction.
    logic         order_seen;
    order_t       exp_order;
    logic [161:0] ctx;
    logic [161:0] ctx_q;
    int           fail_count = 0;

    assign fields     = {opcode, func3, func7, rs1_addr, rs2_addr, rd_addr};
    assign exp_fields = {instruction[6:0], instruction[14:12], instruction[31:25],
                         instruction[19:15], instruction[24:20], instruction[11:7]};

    assign exp_i = {{20{instruction[31]}}, instruction[31:20]};
    assign exp_s = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign exp_b = {{19{instruction[31]}}, instruction[31], instruction[7],
                    instruction[30:25], instruction[11:8], 1'b0};
    assign exp_u = {instruction[31:12], 12'd0};
    assign exp_j = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                    instruction[20], instruction[30:21], 1'b0};

    assign exp_word  = imem_copy[pc_rdata[7:2]];
    assign exp_order = order_seen ? last_order + 64'd1 : '0;

    assign ctx = {instruction, pc_rdata, pc_wdata, commit_order, prediction, valid};

    always_comb begin
        exp_rs1 = shadow[rs1_addr];
        exp_rs2 = shadow[rs2_addr];
        if (reg_load && (rd_sel == rs1_addr)) begin
            exp_rs1 = rd_data;
        end
        if (reg_load && (rd_sel == rs2_addr)) begin
            exp_rs2 = rd_data;
        end
        if (rs1_addr == 5'd0) begin
            exp_rs1 = '0;    // x0 wins over bypass.
        end
        if (rs2_addr == 5'd0) begin
            exp_rs2 = '0;
        end
    end

    always_comb begin
        exp_taken = 1'b0;
        exp_next  = pc_rdata + 32'd4;
        if (instruction[6:0] == op_jal) begin
            exp_taken = 1'b1;
            exp_next  = pc_rdata + exp_j;
        end else if ((instruction[6:0] == op_br) && exp_b[31]) begin
            exp_taken = 1'b1;
            exp_next  = pc_rdata + exp_b;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem_copy[imem_addr] <= imem_wdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else if (reg_load && (rd_sel != 5'd0)) begin
            shadow[rd_sel] <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chain_pc   <= RESET_PC;
            last_order <= '0;
            order_seen <= 1'b0;
            ctx_q      <= '0;
        end else begin
            ctx_q <= ctx;
            if (valid) begin
                last_order <= commit_order;
                order_seen <= 1'b1;
            end
            if (redirect) begin
                chain_pc <= redirect_pc;
            end else if (!stall && valid) begin
                chain_pc <= pc_wdata;
            end
        end
    end

    fetch_word_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> instruction == exp_word)
    else begin
        $error("** Error fetch_word_check: expected %h actual %h", exp_word, instruction);
        fail_count++;
    end

    field_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> fields == exp_fields)
    else begin
        $error("** Error field_check: expected %h actual %h", exp_fields, fields);
        fail_count++;
    end

    imm_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> {i_imm, s_imm, b_imm, u_imm, j_imm} == {exp_i, exp_s, exp_b, exp_u, exp_j})
    else begin
        $error("** Error imm_check: expected %h actual %h",
            {exp_i, exp_s, exp_b, exp_u, exp_j}, {i_imm, s_imm, b_imm, u_imm, j_imm});
        fail_count++;
    end

    reg_read_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> {rs1_data, rs2_data} == {exp_rs1, exp_rs2})
    else begin
        $error("** Error reg_read_check: expected %h actual %h",
            {exp_rs1, exp_rs2}, {rs1_data, rs2_data});
        fail_count++;
    end

    predict_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> {prediction, pc_wdata} == {exp_taken, exp_next})
    else begin
        $error("** Error predict_check: expected %h actual %h",
            {exp_taken, exp_next}, {prediction, pc_wdata});
        fail_count++;
    end

    pc_chain_check: assert property (@(posedge clk) disable iff (!arst_n)
        valid |-> pc_rdata == chain_pc)
    else begin
        $error("** Error pc_chain_check: expected %h actual %h", chain_pc, pc_rdata);
        fail_count++;
    end

    // a new word arrives one past the last valid one.
    order_check: assert property (@(posedge clk) disable iff (!arst_n)
        !stall && !redirect |=> (!valid || (commit_order == exp_order)))
    else begin
        $error("** Error order_check: expected %h actual %h", exp_order, commit_order);
        fail_count++;
    end

    stall_hold_check: assert property (@(posedge clk) disable iff (!arst_n)
        stall && !redirect |=> ctx == ctx_q)
    else begin
        $error("** Error stall_hold_check: expected %h actual %h", ctx_q, ctx);
        fail_count++;
    end

    flush_check: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !valid)
    else begin
        $error("valid still high one cycle after a redirect");
        fail_count++;
    end

    reset_check: assert property (@(posedge clk)
        !arst_n |-> {valid, prediction, commit_order} == '0)
    else begin
        $error("** Error reset_check: expected %h actual %h",
            66'd0, {valid, prediction, commit_order});
        fail_count++;
    end

endmodule : rv32_front_assert

bind rv32_front rv32_front_assert rv32_front_assert_i (.*);

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    // 100 ns period.
    always begin
        #50;
        clk = ~clk;
    end

endmodule : tb_clock_gen

// ==== rv32_front_tb.sv ====
`timescale 1ns/1ps

module rv32_front_tb
    import rv32_front_pkg::*;
();
    logic       clk;
    logic       arst_n;
    logic       stall;
    logic       redirect;
    rv32_word   redirect_pc;
    logic       imem_we;
    imem_addr_t imem_addr;
    rv32_word   imem_wdata;
    logic       reg_load;
    rv32_reg    rd_sel;
    rv32_word   rd_data;
    rv32_opcode opcode;
    logic [2:0] func3;
    logic [6:0] func7;
    rv32_reg    rs1_addr;
    rv32_reg    rs2_addr;
    rv32_reg    rd_addr;
    rv32_word   rs1_data;
    rv32_word   rs2_data;
    rv32_word   i_imm;
    rv32_word   s_imm;
    rv32_word   b_imm;
    rv32_word   u_imm;
    rv32_word   j_imm;
    rv32_word   instruction;
    rv32_word   pc_rdata;
    rv32_word   pc_wdata;
    order_t     commit_order;
    logic       prediction;
    logic       valid;

    logic [31:0] rnd_state;
    int          timeouts;
    int          failures;

    tb_clock_gen clock_gen_i (.clk(clk));

    rv32_front rv32_front_i (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rnd_state = xorshift32(rnd_state);
        return rnd_state;
    endfunction

    // i, s, u, reg and forward branch words only.
    function automatic rv32_word random_instruction();
        logic [31:0] r;
        rv32_word    w;
        r = next_random();
        case (r[2:0])
            3'd0, 3'd1: w = {r[31:7], op_imm};
            3'd2:       w = {r[31:7], op_store};
            3'd3:       w = {r[31:7], op_lui};
            3'd4, 3'd5: w = {r[31:7], op_reg};
            default:    w = {1'b0, r[30:7], op_br};    // bit 31 clear so never taken.
        endcase
        return w;
    endfunction

    function automatic rv32_word jal_word(input rv32_reg rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // beq x0, x0.
    function automatic rv32_word branch_word(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], op_br};
    endfunction

    // jal at 40 jumps to 48 and the branch at 60 back to 4.
    task automatic load_program();
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem_we   = 1'b1;
            imem_addr = imem_addr_t'(i);
            if (i == 40) begin
                imem_wdata = jal_word(5'd1, 21'd32);
            end else if (i == 60) begin
                imem_wdata = branch_word(13'h1f20);    // -224.
            end else begin
                imem_wdata = random_instruction();
            end
            @(posedge clk);
            #10;
        end
        imem_we = 1'b0;
    endtask

    // random stall and write-back, then one clock.
    task automatic step_cycle();
        logic [31:0] r;
        r        = next_random();
        stall    = (r[9:8] == 2'b00);
        reg_load = r[0] | r[1];
        rd_sel   = r[2] ? rs1_addr : r[7:3];    // often hits the bypass.
        rd_data  = next_random();
        @(posedge clk);
        #10;
    endtask

    task automatic run_instructions(input int n, input string what);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while ((seen < n) && (cycles < 8 * n)) begin
            step_cycle();
            cycles++;
            if (valid && !stall) begin
                seen++;
            end
        end
        if (seen < n) begin
            $display("timeout: %s saw %0d of %0d valid instructions in %0d cycles",
                what, seen, n, cycles);
            timeouts++;
        end
    endtask

    task automatic redirect_to(input rv32_word target, input logic with_stall);
        redirect    = 1'b1;
        redirect_pc = target;
        stall       = with_stall;
        @(posedge clk);
        #10;
        redirect = 1'b0;
        stall    = 1'b0;
    endtask

    initial begin
        arst_n      = 1'b1;
        stall       = 1'b1;
        redirect    = 1'b0;
        redirect_pc = '0;
        imem_we     = 1'b0;
        imem_addr   = '0;
        imem_wdata  = '0;
        reg_load    = 1'b0;
        rd_sel      = '0;
        rd_data     = '0;
        rnd_state   = 32'd65518;
        timeouts    = 0;
        failures    = 0;
        #1;
        arst_n = 1'b0;    // clean falling edge.
        repeat (5) @(posedge clk);
        #10;
        arst_n = 1'b1;
        load_program();
        run_instructions(150, "main program");
        redirect_to(32'h0000_0020, 1'b0);
        run_instructions(60, "run after redirect");
        redirect_to(32'h0000_00c0, 1'b1);
        run_instructions(60, "run after redirect under stall");
        @(posedge clk);
        #10;
        failures = rv32_front_i.rv32_front_assert_i.fail_count;
        $display("assertion failures: %0d, timeouts: %0d", failures, timeouts);
        if ((failures == 0) && (timeouts == 0)) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : rv32_front_tb

// ==== rv32_front.f ====
rv32_front_pkg.sv
regfile.sv
fetch_unit.sv
decode_stage.sv
rv32_front.sv
rv32_front_assert.sv
tb_clock_gen.sv
rv32_front_tb.sv

// ==== Makefile ====
TOP := rv32_front_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

obj_dir/V$(TOP): $(shell cat rv32_front.f)
	verilator --binary --timing --assert -f rv32_front.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f rv32_front.f --top-module $(TOP)

clean:
	rm -rf obj_dir
